//--- list.f
rtl/tcb_pkg.sv
rtl/tcb_if.sv
rtl/tcb_dec.sv
rtl/tcb_mem.sv
rtl/tcb_regs.sv
rtl/tcb_top.sv
tb/tcb_assert.sv
tb/tcb_tb.sv

//--- rtl/tcb_dec.sv
////////////////////////////////////////////////////////////////////////////
// TCB address decoder: routes each request to the memory or the register
// block, answers unmapped addresses with err and muxes the responses back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_dec #(
  int unsigned AW  = 16,
  int unsigned DLY = 2
)(
  tcb_if.sub man,
  tcb_if.man mem,
  tcb_if.man regs
);

  import tcb_pkg::*;

  // DLY must agree with the link and leave room for one stage
  if ((DLY != man.DLY) || (DLY < 1)) begin : g_dly_check
    $error("%m: DLY does not match the manager link or is below 1");
  end

  // decoded target of the current request
  tcb_tgt_e tgt;

  // target pipeline, one entry per cycle
  logic     pip_vld [DLY];
  tcb_tgt_e pip_tgt [DLY];

  //////////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////////

  // offset compare, wraps cleanly for a base of zero
  always_comb begin
    if ((man.adr - AW'(MEM_BASE)) < AW'(MEM_SIZE)) begin
      tgt = TGT_MEM;
    end else if ((man.adr - AW'(REG_BASE)) < AW'(REG_SIZE)) begin
      tgt = TGT_REG;
    end else begin
      tgt = TGT_NONE;
    end
  end

  // memory gets the request only when it is the target
  assign mem.vld  = man.vld && (tgt == TGT_MEM);
  assign mem.wen  = man.wen;
  assign mem.adr  = man.adr;
  assign mem.ben  = man.ben;
  assign mem.wdt  = man.wdt;

  // same for the register block
  assign regs.vld = man.vld && (tgt == TGT_REG);
  assign regs.wen = man.wen;
  assign regs.adr = man.adr;
  assign regs.ben = man.ben;
  assign regs.wdt = man.wdt;

  //////////////////////////////////////////////////////////////////////////
  // target pipeline
  //////////////////////////////////////////////////////////////////////////

  // shifts every cycle, idle cycles enter with vld low
  always_ff @(posedge man.bus or negedge man.arst_n) begin
    if (!man.arst_n) begin
      for (int i = 0; i < DLY; i++) begin
        pip_vld[i] <= 1'b0;
        pip_tgt[i] <= TGT_NONE;
      end
    end else begin
      pip_vld[0] <= man.vld;
      pip_tgt[0] <= tgt;
      for (int i = 1; i < DLY; i++) begin
        pip_vld[i] <= pip_vld[i-1];
        pip_tgt[i] <= pip_tgt[i-1];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // response mux
  //////////////////////////////////////////////////////////////////////////

  // oldest entry picks the source
  always_comb begin
    man.rdt = '0;
    man.err = 1'b0;
    if (pip_vld[DLY-1]) begin
      case (pip_tgt[DLY-1])
        TGT_MEM: begin
          man.rdt = mem.rdt;
          man.err = mem.err;
        end
        TGT_REG: begin
          man.rdt = regs.rdt;
          man.err = regs.err;
        end
        // unmapped, decoder answers itself
        default: man.err = 1'b1;
      endcase
    end
  end

endmodule

//--- rtl/tcb_if.sv
////////////////////////////////////////////////////////////////////////////
// TCB link between design modules: one request per cycle on a vld strobe,
// response on rdt/err a fixed DLY cycles after the accept edge
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

interface tcb_if #(
  int unsigned AW  = 16,
  int unsigned DW  = 32,
  int unsigned DLY = 2
)(
  input logic bus,
  input logic arst_n
);

  import tcb_pkg::*;

  // byte enable width follows data width
  localparam int unsigned BW = DW/8;

  // request
  logic          vld;
  tcb_op_e       wen;
  logic [AW-1:0] adr;
  logic [BW-1:0] ben;
  logic [DW-1:0] wdt;
  // response, no valid of its own
  logic [DW-1:0] rdt;
  logic          err;

  // manager side drives the request
  modport man (
    input  bus, arst_n,
    output vld, wen, adr, ben, wdt,
    input  rdt, err
  );

  // subordinate side answers it
  modport sub (
    input  bus, arst_n,
    input  vld, wen, adr, ben, wdt,
    output rdt, err
  );

endinterface

//--- rtl/tcb_mem.sv
////////////////////////////////////////////////////////////////////////////
// TCB memory subordinate: word array with byte-enabled writes, read data
// returned through a full DLY-deep response pipeline, never errors
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_mem #(
  int unsigned DW        = 32,
  int unsigned BW        = DW/8,
  int unsigned DLY       = 2,
  int unsigned MEM_WORDS = 256
)(
  tcb_if.sub sub
);

  import tcb_pkg::*;

  if (DLY != sub.DLY) begin : g_dly_check
    $error("%m: DLY does not match the subordinate link");
  end

  // word index width and byte offset width
  localparam int unsigned IW = $clog2(MEM_WORDS);
  localparam int unsigned OW = $clog2(BW);

  // storage
  logic [DW-1:0] mem_q [MEM_WORDS];

  // response pipeline
  logic [DW-1:0] pip_rdt [DLY];

  // word address below the region size
  logic [IW-1:0] idx;

  assign idx = sub.adr[IW+OW-1:OW];

  //////////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////////

  // per byte lane
  always_ff @(posedge sub.bus) begin
    if (sub.vld && (sub.wen == TCB_WR)) begin
      for (int b = 0; b < BW; b++) begin
        if (sub.ben[b]) begin
          mem_q[idx][8*b +: 8] <= sub.wdt[8*b +: 8];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // read pipeline
  //////////////////////////////////////////////////////////////////////////

  // stage 0 samples the array at the accept edge, rest shift every cycle
  always_ff @(posedge sub.bus or negedge sub.arst_n) begin
    if (!sub.arst_n) begin
      for (int i = 0; i < DLY; i++) begin
        pip_rdt[i] <= '0;
      end
    end else begin
      pip_rdt[0] <= (sub.vld && (sub.wen == TCB_RD)) ? mem_q[idx] : '0;
      for (int i = 1; i < DLY; i++) begin
        pip_rdt[i] <= pip_rdt[i-1];
      end
    end
  end

  assign sub.rdt = pip_rdt[DLY-1];
  // memory has no error case
  assign sub.err = 1'b0;

endmodule

//--- rtl/tcb_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared TCB definitions: opcode, decode target and register offset enums,
// the address map of the subsystem and the register block ID value
////////////////////////////////////////////////////////////////////////////

package tcb_pkg;

  // transfer opcode, carried on the wen signal
  typedef enum logic {
    TCB_RD = 1'b0,
    TCB_WR = 1'b1
  } tcb_op_e;

  // decoded target of a request
  typedef enum logic [1:0] {
    TGT_NONE = 2'd0,
    TGT_MEM  = 2'd1,
    TGT_REG  = 2'd2
  } tcb_tgt_e;

  // word offset inside the register block
  typedef enum logic [1:0] {
    REG_ID      = 2'd0,
    REG_CTL     = 2'd1,
    REG_SCRATCH = 2'd2,
    REG_RSVD    = 2'd3
  } tcb_reg_e;

  //////////////////////////////////////////////////////////////////////////
  // address map, byte addresses
  //////////////////////////////////////////////////////////////////////////

  localparam logic [15:0] MEM_BASE = 16'h0000;
  localparam logic [15:0] MEM_SIZE = 16'h0400;
  localparam logic [15:0] REG_BASE = 16'h1000;
  localparam logic [15:0] REG_SIZE = 16'h0010;

  // read-only identification word of the register block
  localparam logic [31:0] REGS_ID = 32'h7cb5_0001;

endpackage

//--- rtl/tcb_regs.sv
////////////////////////////////////////////////////////////////////////////
// TCB register subordinate: read-only ID, 8-bit CTL driving the ctl port,
// 32-bit SCRATCH, error on ID writes and the reserved slot
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_regs #(
  int unsigned DW  = 32,
  int unsigned BW  = DW/8,
  int unsigned DLY = 2
)(
  tcb_if.sub   sub,
  output logic [7:0] ctl
);

  import tcb_pkg::*;

  if (DLY != sub.DLY) begin : g_dly_check
    $error("%m: DLY does not match the subordinate link");
  end

  // byte offset bits below the word index
  localparam int unsigned OW = $clog2(BW);

  // registers
  logic [7:0]    ctl_q;
  logic [DW-1:0] scratch_q;

  // decode of the current request
  tcb_reg_e      reg_sel;
  logic          bad;
  logic [DW-1:0] rd_val;

  // response pipeline
  logic [DW-1:0] pip_rdt [DLY];
  logic          pip_err [DLY];

  //////////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    reg_sel = tcb_reg_e'(sub.adr[OW+1:OW]);
    // ID is read only, reserved slot rejects everything
    bad = (reg_sel == REG_RSVD) || ((reg_sel == REG_ID) && (sub.wen == TCB_WR));
    case (reg_sel)
      REG_ID:      rd_val = DW'(REGS_ID);
      REG_CTL:     rd_val = DW'(ctl_q);
      REG_SCRATCH: rd_val = scratch_q;
      default:     rd_val = '0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////////
  // register writes, at the accept edge
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge sub.bus or negedge sub.arst_n) begin
    if (!sub.arst_n) begin
      ctl_q     <= '0;
      scratch_q <= '0;
    end else if (sub.vld && (sub.wen == TCB_WR) && !bad) begin
      case (reg_sel)
        // CTL lives in byte lane 0
        REG_CTL: begin
          if (sub.ben[0]) begin
            ctl_q <= sub.wdt[7:0];
          end
        end
        REG_SCRATCH: begin
          for (int b = 0; b < BW; b++) begin
            if (sub.ben[b]) begin
              scratch_q[8*b +: 8] <= sub.wdt[8*b +: 8];
            end
          end
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // response pipeline
  //////////////////////////////////////////////////////////////////////////

  // rdt only loaded for reads, err for any rejected access
  always_ff @(posedge sub.bus or negedge sub.arst_n) begin
    if (!sub.arst_n) begin
      for (int i = 0; i < DLY; i++) begin
        pip_rdt[i] <= '0;
        pip_err[i] <= 1'b0;
      end
    end else begin
      pip_rdt[0] <= (sub.vld && (sub.wen == TCB_RD)) ? rd_val : '0;
      pip_err[0] <= sub.vld && bad;
      for (int i = 1; i < DLY; i++) begin
        pip_rdt[i] <= pip_rdt[i-1];
        pip_err[i] <= pip_err[i-1];
      end
    end
  end

  assign sub.rdt = pip_rdt[DLY-1];
  assign sub.err = pip_err[DLY-1];
  assign ctl     = ctl_q;

endmodule

//--- rtl/tcb_top.sv
////////////////////////////////////////////////////////////////////////////
// TCB subsystem top level: plain manager ports in, decoder feeding the
// memory and the register block, responses DLY cycles after each request
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_top #(
  int unsigned AW        = 16,
  int unsigned DW        = 32,
  int unsigned BW        = DW/8,
  int unsigned DLY       = 2,
  int unsigned MEM_WORDS = 256
)(
  input  logic             bus,
  input  logic             arst_n,
  // request
  input  logic             vld,
  input  tcb_pkg::tcb_op_e wen,
  input  logic [AW-1:0]    adr,
  input  logic [BW-1:0]    ben,
  input  logic [DW-1:0]    wdt,
  // response
  output logic [DW-1:0]    rdt,
  output logic             err,
  // control register output
  output logic [7:0]       ctl
);

  // external manager to decoder
  tcb_if #(.AW(AW), .DW(DW), .DLY(DLY)) tcb_m     (.bus(bus), .arst_n(arst_n));
  // decoder to each subordinate
  tcb_if #(.AW(AW), .DW(DW), .DLY(DLY)) tcb_s_mem (.bus(bus), .arst_n(arst_n));
  tcb_if #(.AW(AW), .DW(DW), .DLY(DLY)) tcb_s_reg (.bus(bus), .arst_n(arst_n));

  // plain ports onto the manager link
  assign tcb_m.vld = vld;
  assign tcb_m.wen = wen;
  assign tcb_m.adr = adr;
  assign tcb_m.ben = ben;
  assign tcb_m.wdt = wdt;
  assign rdt       = tcb_m.rdt;
  assign err       = tcb_m.err;

  tcb_dec #(.AW(AW), .DLY(DLY)) i_tcb_dec (
    .man  (tcb_m),
    .mem  (tcb_s_mem),
    .regs (tcb_s_reg)
  );

  tcb_mem #(.DW(DW), .BW(BW), .DLY(DLY), .MEM_WORDS(MEM_WORDS)) i_tcb_mem (
    .sub (tcb_s_mem)
  );

  tcb_regs #(.DW(DW), .BW(BW), .DLY(DLY)) i_tcb_regs (
    .sub (tcb_s_reg),
    .ctl (ctl)
  );

endmodule

//--- run.sh
#!/bin/sh
# build and run the TCB subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tcb_tb -f list.f -o tcb_sim
./obj_dir/tcb_sim > sim.log
cat sim.log
if grep -qx ">>> PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- tb/tcb_assert.sv
////////////////////////////////////////////////////////////////////////////
// checks bound into the TCB decoder: known err out of reset, err response
// for unmapped requests DLY edges later, strobes follow the address map
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_dec_assert #(
  int unsigned AW  = 16,
  int unsigned DLY = 2
)(
  input logic          bus,
  input logic          arst_n,
  input logic          vld,
  input logic [AW-1:0] adr,
  input logic          mem_vld,
  input logic          reg_vld,
  input logic          err
);

  import tcb_pkg::*;

  // regions are aligned powers of two, mask compare against the base
  logic in_mem;
  logic in_reg;

  assign in_mem = ((adr ^ AW'(MEM_BASE)) & ~AW'(MEM_SIZE - 16'd1)) == '0;
  assign in_reg = ((adr ^ AW'(REG_BASE)) & ~AW'(REG_SIZE - 16'd1)) == '0;

  // response error always driven once out of reset
  a_err_known: assert property (@(posedge bus) disable iff (!arst_n) !$isunknown(err))
    else $error("err is unknown after reset");

  // decoder answers an unmapped request itself
  a_unmapped_err: assert property (@(posedge bus) disable iff (!arst_n)
    (vld && !in_mem && !in_reg) |-> ##DLY err)
    else $error("unmapped request got no err response after DLY cycles");

  // each strobe follows its own region, disjoint so never both at once
  a_sub_sel: assert property (@(posedge bus) disable iff (!arst_n)
    (mem_vld == (vld && in_mem)) && (reg_vld == (vld && in_reg)))
    else $error("subordinate strobe does not match the address map");

endmodule

bind tcb_dec tcb_dec_assert #(.AW(AW), .DLY(DLY)) i_tcb_dec_assert (
  .bus     (man.bus),
  .arst_n  (man.arst_n),
  .vld     (man.vld),
  .adr     (man.adr),
  .mem_vld (mem.vld),
  .reg_vld (regs.vld),
  .err     (man.err)
);

//--- tb/tcb_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the TCB subsystem: directed table of register and memory
// transfers, then a seeded random stream checked against a local model
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tcb_tb;

  import tcb_pkg::*;

  localparam int unsigned AW        = 16;
  localparam int unsigned DW        = 32;
  localparam int unsigned BW        = DW/8;
  localparam int unsigned DLY       = 2;
  localparam int unsigned MEM_WORDS = 256;
  // random phase, first WIN_WORDS+1 rows preload the model
  localparam int          N_RND     = 200;
  localparam int          WIN_WORDS = 16;
  localparam logic [AW-1:0] WIN_BASE = 16'h0100;
  localparam int          DRAIN_MAX = 40;

  // one stimulus row with its expected response
  typedef struct {
    string         name;
    tcb_op_e       op;
    logic [AW-1:0] adr;
    logic [BW-1:0] ben;
    logic [DW-1:0] wdt;
    logic [DW-1:0] rdt;
    logic          err;
    logic          chk;
  } row_t;

  logic          bus;
  logic          arst_n;
  logic          vld;
  tcb_op_e       wen;
  logic [AW-1:0] adr;
  logic [BW-1:0] ben;
  logic [DW-1:0] wdt;
  logic [DW-1:0] rdt;
  logic          err;
  logic [7:0]    ctl;

  row_t          tbl [$];
  row_t          exp_q [$];
  // accept history, entry DLY-1 marks a response cycle
  logic          age [DLY];
  logic [DW-1:0] mdl_mem [WIN_WORDS];
  logic [DW-1:0] mdl_scr;
  logic [31:0]   rng;
  int            n_tests = 0;
  int            n_err   = 0;

  tcb_top #(.AW(AW), .DW(DW), .BW(BW), .DLY(DLY), .MEM_WORDS(MEM_WORDS)) i_tcb_top (
    .bus (bus), .arst_n (arst_n), .vld (vld), .wen (wen), .adr (adr),
    .ben (ben), .wdt (wdt), .rdt (rdt), .err (err), .ctl (ctl)
  );

  initial bus = 1'b0;
  always #4 bus = ~bus;

  // reset held for 8 cycles
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge bus);
    #1;
    arst_n = 1'b1;
  end

  //////////////////////////////////////////////////////////////////////////
  // helpers and compare tasks
  //////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // only enabled byte lanes take new data
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
      input logic [DW-1:0] new_d, input logic [BW-1:0] be);
    logic [DW-1:0] res;
    res = old;
    for (int b = 0; b < BW; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_d[8*b +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_rdt(input string name, input logic [DW-1:0] expv,
      input logic [DW-1:0] actv, output bit ok);
    ok = (actv === expv);
    if (!ok) begin
      $display("[ERROR] %s: rdt expected %h, got %h", name, expv, actv);
      n_err++;
    end
  endtask

  task automatic check_err(input string name, input logic expv, input logic actv,
      output bit ok);
    ok = (actv === expv);
    if (!ok) begin
      $display("[ERROR] %s: err expected %b, got %b", name, expv, actv);
      n_err++;
    end
  endtask

  task automatic check_ctl(input string name, input logic [7:0] expv,
      input logic [7:0] actv);
    n_tests++;
    if (actv !== expv) begin
      $display("[ERROR] %s: ctl expected %h, got %h", name, expv, actv);
      n_err++;
    end else begin
      $display("[ OK  ] %s", name);
    end
  endtask

  task automatic add_row(input string name, input tcb_op_e op, input logic [AW-1:0] a,
      input logic [BW-1:0] be, input logic [DW-1:0] wd, input logic [DW-1:0] rd,
      input logic er, input logic ck);
    row_t r;
    r = '{name, op, a, be, wd, rd, er, ck};
    tbl.push_back(r);
  endtask

  // random row, early rows fill the model window and SCRATCH with full words
  task automatic make_rnd_row(input int idx, output row_t r);
    logic [31:0] pick;
    logic [3:0]  w;
    logic        to_reg;
    rng    = xorshift(rng);
    pick   = rng;
    rng    = xorshift(rng);
    r.name = $sformatf("rnd_%0d", idx);
    r.op   = pick[0] ? TCB_WR : TCB_RD;
    r.ben  = pick[7:4];
    r.wdt  = rng;
    r.rdt  = '0;
    r.err  = 1'b0;
    w      = pick[11:8];
    to_reg = (pick[13:12] == 2'd0);
    if (idx <= WIN_WORDS) begin
      r.op   = TCB_WR;
      r.ben  = '1;
      w      = idx[3:0];
      to_reg = (idx == WIN_WORDS);
    end
    r.chk = (r.op == TCB_RD);
    if (to_reg) begin
      r.adr = REG_BASE + 16'h0008;
      if (r.op == TCB_WR) mdl_scr = merge_bytes(mdl_scr, r.wdt, r.ben);
      else r.rdt = mdl_scr;
    end else begin
      r.adr = WIN_BASE + {10'd0, w, 2'b00};
      if (r.op == TCB_WR) mdl_mem[w] = merge_bytes(mdl_mem[w], r.wdt, r.ben);
      else r.rdt = mdl_mem[w];
    end
  endtask

  // one row per cycle, back to back
  task automatic apply_table();
    foreach (tbl[i]) begin
      @(posedge bus);
      #1;
      vld = 1'b1;
      wen = tbl[i].op;
      adr = tbl[i].adr;
      ben = tbl[i].ben;
      wdt = tbl[i].wdt;
      exp_q.push_back(tbl[i]);
    end
    @(posedge bus);
    #1;
    vld = 1'b0;
  endtask

  task automatic drain_queue();
    int cyc;
    cyc = 0;
    while ((exp_q.size() != 0) && (cyc < DRAIN_MAX)) begin
      @(posedge bus);
      cyc++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout while waiting for %0d outstanding responses", exp_q.size());
      n_err++;
      exp_q.delete();
    end
  endtask

  //////////////////////////////////////////////////////////////////////////
  // response checker
  //////////////////////////////////////////////////////////////////////////

  always @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DLY; i++) age[i] <= 1'b0;
    end else begin
      age[0] <= vld;
      for (int i = 1; i < DLY; i++) age[i] <= age[i-1];
    end
  end

  // mid cycle, response of the oldest request is stable here
  always @(negedge bus) begin
    row_t r;
    bit   ok_e;
    bit   ok_d;
    if (age[DLY-1] === 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("response cycle seen with no request outstanding");
        n_err++;
      end else begin
        r = exp_q.pop_front();
        n_tests++;
        ok_d = 1'b1;
        check_err(r.name, r.err, err, ok_e);
        if (r.chk && !r.err) check_rdt(r.name, r.rdt, rdt, ok_d);
        if (ok_e && ok_d) $display("[ OK  ] %s", r.name);
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////////

  initial begin
    int   wait_cyc;
    row_t r;
    vld     = 1'b0;
    wen     = TCB_RD;
    adr     = '0;
    ben     = '0;
    wdt     = '0;
    rng     = 32'h66a6;
    mdl_scr = '0;
    wait_cyc = 0;
    while ((arst_n !== 1'b1) && (wait_cyc < 50)) begin
      @(posedge bus);
      wait_cyc++;
    end
    if (arst_n !== 1'b1) begin
      $display("reset did not release in time");
      n_err++;
    end
    check_ctl("ctl_after_reset", 8'h00, ctl);
    // name, op, adr, ben, wdt, expected rdt, expected err, check rdt
    add_row("rd_id_first",  TCB_RD, 16'h1000, 4'hf, '0, REGS_ID, 1'b0, 1'b1);
    add_row("mem_wr",       TCB_WR, 16'h0010, 4'hf, 32'hdead_beef, '0, 1'b0, 1'b0);
    add_row("mem_rd",       TCB_RD, 16'h0010, 4'hf, '0, 32'hdead_beef, 1'b0, 1'b1);
    add_row("mem_wr_part",  TCB_WR, 16'h0010, 4'h5, 32'h1122_3344, '0, 1'b0, 1'b0);
    add_row("mem_rd_part",  TCB_RD, 16'h0010, 4'hf, '0, 32'hde22_be44, 1'b0, 1'b1);
    add_row("scr_wr",       TCB_WR, 16'h1008, 4'hf, 32'ha5a5_5a5a, '0, 1'b0, 1'b0);
    add_row("scr_rd",       TCB_RD, 16'h1008, 4'hf, '0, 32'ha5a5_5a5a, 1'b0, 1'b1);
    add_row("ctl_wr",       TCB_WR, 16'h1004, 4'h1, 32'hffff_ff3c, '0, 1'b0, 1'b0);
    add_row("ctl_wr_noben", TCB_WR, 16'h1004, 4'he, 32'hffff_ffff, '0, 1'b0, 1'b0);
    add_row("ctl_rd",       TCB_RD, 16'h1004, 4'hf, '0, 32'h0000_003c, 1'b0, 1'b1);
    add_row("id_wr",        TCB_WR, 16'h1000, 4'hf, '0, '0, 1'b1, 1'b0);
    add_row("id_rd",        TCB_RD, 16'h1000, 4'hf, '0, REGS_ID, 1'b0, 1'b1);
    add_row("rsvd_wr",      TCB_WR, 16'h100c, 4'hf, 32'h1234_5678, '0, 1'b1, 1'b0);
    add_row("rsvd_rd",      TCB_RD, 16'h100c, 4'hf, '0, '0, 1'b1, 1'b0);
    // aliases of word 0x0010 and SCRATCH if they leaked through
    add_row("unmap_wr_mem", TCB_WR, 16'h0410, 4'hf, 32'hcafe_f00d, '0, 1'b1, 1'b0);
    add_row("unmap_wr_reg", TCB_WR, 16'h1018, 4'hf, 32'h0bad_0bad, '0, 1'b1, 1'b0);
    add_row("unmap_rd",     TCB_RD, 16'h8000, 4'hf, '0, '0, 1'b1, 1'b0);
    add_row("mem_rd_after", TCB_RD, 16'h0010, 4'hf, '0, 32'hde22_be44, 1'b0, 1'b1);
    add_row("scr_rd_after", TCB_RD, 16'h1008, 4'hf, '0, 32'ha5a5_5a5a, 1'b0, 1'b1);
    add_row("ctl_rd_after", TCB_RD, 16'h1004, 4'hf, '0, 32'h0000_003c, 1'b0, 1'b1);
    apply_table();
    drain_queue();
    check_ctl("ctl_port", 8'h3c, ctl);
    // random stream over the memory window and SCRATCH
    tbl.delete();
    for (int i = 0; i < N_RND; i++) begin
      make_rnd_row(i, r);
      tbl.push_back(r);
    end
    apply_table();
    drain_queue();
    $display("%0d tests, %0d errors", n_tests, n_err);
    if (n_err == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
